/* include/vram_sys_config.svh */
/*
 * Build-time sizing of the video memory subsystem.
 * Included by the package and by any module that sizes memories or counters.
 */
`ifndef VRAM_SYS_CONFIG_SVH
`define VRAM_SYS_CONFIG_SVH

// word address bits, any value up to 16 works
// 12 gives 4096 words for simulation
`define VRAM_ADDR_W 12

// words fetched per video line before the index wraps
`define VGEN_LINE_WORDS 16

// cycles between two fetch reads
// must stay at 2 or more so each read can finish before the next
`define VGEN_INTERVAL 4

`endif

/* hw/vram_sys_pkg.sv */
/*
 * Shared types of the video memory subsystem.
 * Every block refers to them by scoped name.
 */
`include "vram_sys_config.svh"

package vram_sys_pkg;

    // one memory word
    typedef logic [15:0] vram_word_t;

    // word address, sized by the config header
    typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;

    // nibble write enables
    // bit n covers data bits 4n+3 down to 4n
    typedef logic [3:0] vram_mask_t;

    // one memory access as a requester presents it
    // wr clear means read, and mask and data are then ignored
    typedef struct packed {
        logic       wr;
        vram_mask_t mask;
        vram_addr_t addr;
        vram_word_t data;
    } vram_req_t;

endpackage

/* hw/vram.sv */
/*
 * Single-port synchronous video memory.
 * Writes honour a nibble mask, and read data is registered one cycle after the select.
 */
`default_nettype none
`timescale 1ns/100ps

`include "vram_sys_config.svh"

module vram (
    input  wire logic                      clk,
    input  wire logic                      sel_i,
    input  wire vram_sys_pkg::vram_req_t   req_i,
    output      vram_sys_pkg::vram_word_t  data_o
);

    localparam int DEPTH = 1 << `VRAM_ADDR_W;

    vram_sys_pkg::vram_word_t mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (req_i.wr) begin
                // only touch the enabled nibbles
                for (int n = 0; n < 4; n++) begin
                    if (req_i.mask[n]) begin
                        mem[req_i.addr][4*n +: 4] <= req_i.data[4*n +: 4];
                    end
                end
            end else begin
                data_o <= mem[req_i.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/vram_arb.sv */
/*
 * Fixed-priority arbiter in front of the video memory.
 * Order is video fetch, then host, then blitter. Acks are registered one cycle after grant.
 */
`default_nettype none
`timescale 1ns/100ps

module vram_arb (
    input  wire logic                      clk,
    input  wire logic                      rst_i,

    // video fetch, read only and never acked
    input  wire logic                      vgen_sel_i,
    input  wire vram_sys_pkg::vram_addr_t  vgen_addr_i,

    // host register port
    input  wire logic                      host_sel_i,
    input  wire vram_sys_pkg::vram_req_t   host_req_i,
    output      logic                      host_ack_o,

    // fill blitter
    input  wire logic                      blit_sel_i,
    input  wire vram_sys_pkg::vram_req_t   blit_req_i,
    output      logic                      blit_ack_o,

    // read data, valid in the ack cycle of a read
    output      vram_sys_pkg::vram_word_t  vram_data_o
);

    vram_sys_pkg::vram_req_t vgen_req;
    vram_sys_pkg::vram_req_t mem_req;
    logic                    mem_sel;
    logic                    host_ack_next;
    logic                    blit_ack_next;

    // fetch only reads, so mask and data stay clear
    assign vgen_req = '{wr: 1'b0, mask: '0, addr: vgen_addr_i, data: '0};

    // a raised ack blocks a second grant of the same request
    always_comb begin
        host_ack_next = 1'b0;
        blit_ack_next = 1'b0;
        mem_sel       = 1'b0;
        mem_req       = '0;
        if (vgen_sel_i) begin
            mem_sel = 1'b1;
            mem_req = vgen_req;
        end else if (host_sel_i && !host_ack_o) begin
            host_ack_next = 1'b1;
            mem_sel       = 1'b1;
            mem_req       = host_req_i;
        end else if (blit_sel_i && !blit_ack_o) begin
            blit_ack_next = 1'b1;
            mem_sel       = 1'b1;
            mem_req       = blit_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            host_ack_o <= 1'b0;
            blit_ack_o <= 1'b0;
        end else begin
            host_ack_o <= host_ack_next;
            blit_ack_o <= blit_ack_next;
        end
    end

    vram u_vram (
        .clk    (clk),
        .sel_i  (mem_sel),
        .req_i  (mem_req),
        .data_o (vram_data_o)
    );

endmodule

`default_nettype wire

/* hw/vgen_fetch.sv */
/*
 * Video line fetch engine.
 * While enabled it reads one word every VGEN_INTERVAL cycles from base plus a wrapping index,
 * and presents each returned word with a one-cycle valid pulse.
 */
`default_nettype none
`timescale 1ns/100ps

`include "vram_sys_config.svh"

module vgen_fetch (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      enable_i,
    input  wire vram_sys_pkg::vram_addr_t  base_addr_i,
    input  wire vram_sys_pkg::vram_word_t  vram_data_i,
    output      logic                      vgen_sel_o,
    output      vram_sys_pkg::vram_addr_t  vgen_addr_o,
    output      vram_sys_pkg::vram_word_t  pixel_word_o,
    output      logic                      pixel_valid_o
);

    localparam int CNT_W = $clog2(`VGEN_INTERVAL);
    localparam int IDX_W = (`VGEN_LINE_WORDS > 1) ? $clog2(`VGEN_LINE_WORDS) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`VGEN_INTERVAL - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`VGEN_LINE_WORDS - 1);

    logic [CNT_W-1:0] interval_cnt;
    logic [IDX_W-1:0] word_idx;
    logic             rd_pending;

    // address wraps at the memory depth through the add width
    assign vgen_addr_o = base_addr_i + vram_sys_pkg::vram_addr_t'(word_idx);

    // interval timer and line index, both cleared while disabled
    always_ff @(posedge clk) begin
        if (rst_i || !enable_i) begin
            interval_cnt <= '0;
            word_idx     <= '0;
            vgen_sel_o   <= 1'b0;
        end else begin
            vgen_sel_o <= 1'b0;
            if (interval_cnt == CNT_LAST) begin
                interval_cnt <= '0;
                vgen_sel_o   <= 1'b1;
            end else begin
                interval_cnt <= interval_cnt + 1'b1;
            end
            // step once the current address has gone out
            if (vgen_sel_o) begin
                word_idx <= (word_idx == IDX_LAST) ? '0 : word_idx + 1'b1;
            end
        end
    end

    // memory data is valid the cycle after the read
    // capture it there and flag it one cycle later
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_pending    <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else begin
            rd_pending    <= vgen_sel_o;
            pixel_valid_o <= rd_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) begin
            pixel_word_o <= vram_data_i;
        end
    end

endmodule

`default_nettype wire

/* hw/blit_fill.sv */
/*
 * Block-fill blitter.
 * A start pulse while idle writes one value to count words upward from dst,
 * one word per arbiter ack. done_o pulses the cycle after the last ack.
 */
`default_nettype none
`timescale 1ns/100ps

module blit_fill (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      start_i,
    input  wire vram_sys_pkg::vram_addr_t  dst_addr_i,
    input  wire vram_sys_pkg::vram_addr_t  count_i,
    input  wire vram_sys_pkg::vram_word_t  fill_data_i,
    input  wire logic                      ack_i,
    output      logic                      sel_o,
    output      vram_sys_pkg::vram_req_t   req_o,
    output      logic                      busy_o,
    output      logic                      done_o
);

    localparam vram_sys_pkg::vram_addr_t ADDR_ONE = vram_sys_pkg::vram_addr_t'(1);

    vram_sys_pkg::vram_addr_t cur_addr;
    vram_sys_pkg::vram_addr_t remaining;
    vram_sys_pkg::vram_word_t fill_word;
    logic                     busy;

    // full-mask write of the latched value
    assign req_o  = '{wr: 1'b1, mask: '1, addr: cur_addr, data: fill_word};
    assign sel_o  = busy;
    assign busy_o = busy;

    // control state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy   <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!busy) begin
                if (start_i) begin
                    // zero count ends straight away
                    if (count_i == '0) begin
                        done_o <= 1'b1;
                    end else begin
                        busy <= 1'b1;
                    end
                end
            end else if (ack_i && remaining == ADDR_ONE) begin
                busy   <= 1'b0;
                done_o <= 1'b1;
            end
        end
    end

    // address, count and value
    always_ff @(posedge clk) begin
        if (!busy && start_i) begin
            cur_addr  <= dst_addr_i;
            remaining <= count_i;
            fill_word <= fill_data_i;
        end else if (busy && ack_i) begin
            // request changes in the ack cycle, never granted twice
            cur_addr  <= cur_addr + ADDR_ONE;
            remaining <= remaining - ADDR_ONE;
        end
    end

endmodule

`default_nettype wire

/* hw/vram_sys_top.sv */
/*
 * Top level of the video memory subsystem.
 * Joins the arbiter and its memory with the fetch engine and the fill blitter,
 * and exposes the host port, pixel stream and blitter controls.
 */
`default_nettype none
`timescale 1ns/100ps

module vram_sys_top (
    input  wire logic                      clk,
    input  wire logic                      rst_i,

    // host register port
    input  wire logic                      host_sel_i,
    input  wire vram_sys_pkg::vram_req_t   host_req_i,
    output      logic                      host_ack_o,
    output      vram_sys_pkg::vram_word_t  host_data_o,

    // video fetch
    input  wire logic                      vgen_enable_i,
    input  wire vram_sys_pkg::vram_addr_t  vgen_base_i,
    output      vram_sys_pkg::vram_word_t  pixel_word_o,
    output      logic                      pixel_valid_o,

    // fill blitter
    input  wire logic                      blit_start_i,
    input  wire vram_sys_pkg::vram_addr_t  blit_dst_i,
    input  wire vram_sys_pkg::vram_addr_t  blit_count_i,
    input  wire vram_sys_pkg::vram_word_t  blit_data_i,
    output      logic                      blit_busy_o,
    output      logic                      blit_done_o
);

    logic                     vgen_sel;
    vram_sys_pkg::vram_addr_t vgen_addr;
    logic                     blit_sel;
    vram_sys_pkg::vram_req_t  blit_req;
    logic                     blit_ack;
    vram_sys_pkg::vram_word_t vram_data;

    // shared read data, the host samples it on its ack
    assign host_data_o = vram_data;

    vram_arb u_arb (
        .clk         (clk),
        .rst_i       (rst_i),
        .vgen_sel_i  (vgen_sel),
        .vgen_addr_i (vgen_addr),
        .host_sel_i  (host_sel_i),
        .host_req_i  (host_req_i),
        .host_ack_o  (host_ack_o),
        .blit_sel_i  (blit_sel),
        .blit_req_i  (blit_req),
        .blit_ack_o  (blit_ack),
        .vram_data_o (vram_data)
    );

    vgen_fetch u_vgen (
        .clk           (clk),
        .rst_i         (rst_i),
        .enable_i      (vgen_enable_i),
        .base_addr_i   (vgen_base_i),
        .vram_data_i   (vram_data),
        .vgen_sel_o    (vgen_sel),
        .vgen_addr_o   (vgen_addr),
        .pixel_word_o  (pixel_word_o),
        .pixel_valid_o (pixel_valid_o)
    );

    blit_fill u_blit (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (blit_start_i),
        .dst_addr_i  (blit_dst_i),
        .count_i     (blit_count_i),
        .fill_data_i (blit_data_i),
        .ack_i       (blit_ack),
        .sel_o       (blit_sel),
        .req_o       (blit_req),
        .busy_o      (blit_busy_o),
        .done_o      (blit_done_o)
    );

endmodule

`default_nettype wire

/* test/vram_sys_tb.sv */
/*
 * Self-checking testbench of the video memory subsystem.
 * Keeps a model of the memory, drives host, blitter and fetch engine on the falling edge,
 * and checks host reads and fetched pixels against the model just after each rising edge.
 */
`timescale 1ns/100ps

`include "vram_sys_config.svh"

module vram_sys_tb;

    localparam int DEPTH     = 1 << `VRAM_ADDR_W;
    localparam int LINE      = `VGEN_LINE_WORDS;
    localparam int N_ADDR    = 8;
    localparam int BLIT_MAX  = 40;
    localparam int HOST_SPAN = 16;
    localparam int N_MIXED   = 24;
    // worst case per host access or blit word, one fetch slot included
    localparam int OP_CYCLES = 2 * `VGEN_INTERVAL;
    localparam int HOST_OPS  = 3 * N_ADDR + (BLIT_MAX + 7) + LINE
                             + (LINE + HOST_SPAN + N_MIXED + BLIT_MAX + 4);
    localparam int PIXELS    = 3 * LINE + 4;
    localparam int WATCHDOG_CYCLES = (HOST_OPS + 2 * BLIT_MAX) * OP_CYCLES
                                   + PIXELS * `VGEN_INTERVAL + 500;

    logic                     clk;
    logic                     rst_i;
    logic                     host_sel_i;
    vram_sys_pkg::vram_req_t  host_req_i;
    logic                     host_ack_o;
    vram_sys_pkg::vram_word_t host_data_o;
    logic                     vgen_enable_i;
    vram_sys_pkg::vram_addr_t vgen_base_i;
    vram_sys_pkg::vram_word_t pixel_word_o;
    logic                     pixel_valid_o;
    logic                     blit_start_i;
    vram_sys_pkg::vram_addr_t blit_dst_i;
    vram_sys_pkg::vram_addr_t blit_count_i;
    vram_sys_pkg::vram_word_t blit_data_i;
    logic                     blit_busy_o;
    logic                     blit_done_o;

    logic [15:0] model_mem [0:DEPTH-1];
    integer      seed = 32'h3d0d;
    string       cur_test;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          host_req_count = 0;
    int          host_ack_count = 0;
    int          blit_done_count = 0;
    int          blit_target = 0;
    int          pixel_count = 0;
    int          fetch_idx = 0;
    int          pixel_addr;
    int          read_addr;
    logic        read_pending = 1'b0;
    logic [15:0] read_expect;

    vram_sys_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected word after a masked write
    function automatic logic [15:0] merge_word(input logic [15:0] old_word,
                                               input logic [15:0] new_word,
                                               input logic [3:0]  mask);
        logic [15:0] result;
        result = old_word;
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) begin
                result[4*n +: 4] = new_word[4*n +: 4];
            end
        end
        return result;
    endfunction

    function automatic int wrap_addr(input int addr);
        return addr % DEPTH;
    endfunction

    // odd multiplier keeps every address distinct
    function automatic logic [15:0] pattern_word(input int addr);
        return 16'(addr) * 16'h9e37 ^ 16'h5a5a;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                 cur_test, what, expected, actual);
        error_count++;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        if (host_ack_count != host_req_count) begin
            report_mismatch("host acknowledge count", host_req_count, host_ack_count);
        end
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", cur_test, error_count - test_errors);
        end
    endtask

    // one host access, held until its acknowledge
    task automatic host_access(input logic wr, input logic [3:0] mask, input int addr,
                               input logic [15:0] data);
        @(negedge clk);
        host_req_i.wr   = wr;
        host_req_i.mask = mask;
        host_req_i.addr = vram_sys_pkg::vram_addr_t'(addr);
        host_req_i.data = data;
        host_sel_i      = 1'b1;
        read_pending    = !wr;
        read_addr       = addr;
        read_expect     = model_mem[addr];
        if (wr) begin
            model_mem[addr] = merge_word(model_mem[addr], data, mask);
        end
        host_req_count++;
        wait (host_ack_o);
        @(negedge clk);
        host_sel_i = 1'b0;
    endtask

    task automatic preload(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            host_access(1'b1, 4'hf, wrap_addr(base + i), pattern_word(wrap_addr(base + i)));
        end
    endtask

    task automatic read_back(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            host_access(1'b0, 4'h0, wrap_addr(base + i), 16'h0);
        end
    endtask

    task automatic blit_start(input int dst, input int count, input logic [15:0] value);
        @(negedge clk);
        blit_target  = blit_done_count + 1;
        blit_dst_i   = vram_sys_pkg::vram_addr_t'(dst);
        blit_count_i = vram_sys_pkg::vram_addr_t'(count);
        blit_data_i  = value;
        blit_start_i = 1'b1;
        for (int i = 0; i < count; i++) begin
            model_mem[wrap_addr(dst + i)] = value;
        end
        @(posedge clk);
        #1;
        if (count == 0 && (blit_busy_o !== 1'b0 || blit_done_o !== 1'b1)) begin
            $display("** Error [%s] zero-count blit did not end at once with done", cur_test);
            error_count++;
        end
        if (count != 0 && blit_busy_o !== 1'b1) begin
            $display("** Error [%s] blitter did not turn busy after start", cur_test);
            error_count++;
        end
        @(negedge clk);
        blit_start_i = 1'b0;
    endtask

    task automatic blit_wait();
        wait (blit_done_count >= blit_target);
        @(negedge clk);
        if (blit_busy_o !== 1'b0) begin
            $display("** Error [%s] blitter still busy after done", cur_test);
            error_count++;
        end
    endtask

    // drop enable right after a pixel so no read is in flight
    task automatic stop_fetch();
        int seen;
        seen = pixel_count;
        wait (pixel_count != seen);
        @(negedge clk);
        vgen_enable_i = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic test_reset();
        begin_test("reset");
        repeat (3) begin
            @(posedge clk);
            #1;
            if ({host_ack_o, pixel_valid_o, blit_busy_o, blit_done_o} !== 4'b0000) begin
                report_mismatch("ack, valid, busy, done", 4'b0000,
                                {host_ack_o, pixel_valid_o, blit_busy_o, blit_done_o});
            end
        end
        end_test();
    endtask

    task automatic test_host();
        int addrs [N_ADDR];
        begin_test("host write and read back");
        for (int i = 0; i < N_ADDR; i++) begin
            addrs[i] = rand_range(12'h040, 12'h0ff);
            host_access(1'b1, 4'hf, addrs[i], 16'($random(seed)));
        end
        for (int i = 0; i < N_ADDR; i++) begin
            host_access(1'b1, 4'($random(seed)), addrs[rand_range(0, N_ADDR - 1)],
                        16'($random(seed)));
        end
        for (int i = 0; i < N_ADDR; i++) begin
            host_access(1'b0, 4'h0, addrs[i], 16'h0);
        end
        end_test();
    endtask

    task automatic test_blit();
        int dst;
        int count;
        begin_test("blit fill");
        dst   = 12'h200 + rand_range(0, 15);
        count = rand_range(8, BLIT_MAX);
        preload(dst - 1, 1);
        preload(dst + count, 1);
        blit_start(dst, count, 16'($random(seed)));
        blit_wait();
        read_back(dst - 1, count + 2);
        // zero count must leave memory alone
        blit_start(dst, 0, ~model_mem[dst]);
        blit_wait();
        read_back(dst - 1, 3);
        end_test();
    endtask

    task automatic test_fetch();
        int seen;
        begin_test("video fetch");
        // line crosses the top of memory
        preload(DEPTH - 6, LINE);
        @(negedge clk);
        vgen_base_i   = vram_sys_pkg::vram_addr_t'(DEPTH - 6);
        vgen_enable_i = 1'b1;
        seen = pixel_count;
        wait (pixel_count >= seen + 2 * LINE + 2);
        stop_fetch();
        end_test();
    endtask

    task automatic test_contention();
        int dst;
        int count;
        int seen;
        begin_test("contention");
        dst   = 12'h400;
        count = rand_range(BLIT_MAX / 2, BLIT_MAX);
        preload(12'h100, LINE);
        preload(12'h800, HOST_SPAN);
        preload(dst - 1, 1);
        preload(dst + count, 1);
        @(negedge clk);
        vgen_base_i   = 12'h100;
        vgen_enable_i = 1'b1;
        seen = pixel_count;
        blit_start(dst, count, 16'($random(seed)));
        fork
            for (int i = 0; i < N_MIXED; i++) begin
                host_access(1'($random(seed)), 4'($random(seed)),
                            12'h800 + rand_range(0, HOST_SPAN - 1), 16'($random(seed)));
            end
            blit_wait();
        join
        read_back(dst - 1, count + 2);
        wait (pixel_count >= seen + LINE);
        stop_fetch();
        end_test();
    endtask

    // host read data and acknowledge count
    always @(posedge clk) begin
        #1;
        if (host_ack_o) begin
            host_ack_count++;
            if (read_pending && host_data_o !== read_expect) begin
                report_mismatch($sformatf("host read at 0x%0h", read_addr),
                                read_expect, host_data_o);
            end
        end
        if (blit_done_o) begin
            blit_done_count++;
        end
    end

    // fetched words against the model at base plus running index
    always @(posedge clk) begin
        #1;
        if (pixel_valid_o) begin
            pixel_addr = wrap_addr(int'(vgen_base_i) + fetch_idx);
            if (pixel_word_o !== model_mem[pixel_addr]) begin
                report_mismatch($sformatf("pixel from 0x%0h", pixel_addr),
                                model_mem[pixel_addr], pixel_word_o);
            end
            fetch_idx = (fetch_idx + 1) % LINE;
            pixel_count++;
        end
        if (!vgen_enable_i) begin
            fetch_idx = 0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run still going after %0d cycles, stopping", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_i         = 1'b1;
        host_sel_i    = 1'b0;
        host_req_i    = '0;
        vgen_enable_i = 1'b0;
        vgen_base_i   = '0;
        blit_start_i  = 1'b0;
        blit_dst_i    = '0;
        blit_count_i  = '0;
        blit_data_i   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        test_reset();
        test_host();
        test_blit();
        test_fetch();
        test_contention();
        $display("summary: %0d tests passed, %0d failed, %0d errors, %0d pixels checked",
                 tests_passed, tests_failed, error_count, pixel_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vram_sys.f */
+incdir+include
hw/vram_sys_pkg.sv
hw/vram.sv
hw/vram_arb.sv
hw/vgen_fetch.sv
hw/blit_fill.sv
hw/vram_sys_top.sv
test/vram_sys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the vram_sys testbench with Verilator and runs it.
# The exit status is non-zero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module vram_sys_tb --Mdir "$BUILD_DIR" -o vram_sys_sim \
    -f vram_sys.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/vram_sys_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
